// ==== build.f ====
l2_cfg_pkg.sv
l2_coh_pkg.sv
l2_way_wr_if.sv
l2_wr_decode.sv
l2_way_store.sv
l2_evict_store.sv
l2_localmem.sv
l2_localmem_assertions.sv
tb_l2_localmem.sv

// ==== l2_cfg_pkg.sv ====
// geometry of the L2 cache storage and the vector types sized from it
// shared by every design file through scoped names
`default_nettype none

package l2_cfg_pkg;

    // ways per set and the width of a way index
    localparam int L2_WAYS     = 4;
    localparam int L2_WAY_BITS = 2;

    // set index width and the set count it gives
    localparam int L2_SET_BITS = 4;
    localparam int L2_SETS     = 1 << L2_SET_BITS;

    localparam int L2_TAG_BITS  = 12;
    localparam int L2_LINE_BITS = 64;

    // set index into every per-set array
    typedef logic [L2_SET_BITS-1:0] l2_set_t;

    // way index, also the format of the stored evict way
    typedef logic [L2_WAY_BITS-1:0] l2_way_t;

    typedef logic [L2_TAG_BITS-1:0] l2_tag_t;

    // one full data line
    typedef logic [L2_LINE_BITS-1:0] line_t;

endpackage

`default_nettype wire

// ==== l2_coh_pkg.sv ====
// coherence-side field types and state codes held by the L2 storage
`default_nettype none

package l2_coh_pkg;

    localparam int STATE_BITS = 3;

    typedef logic [STATE_BITS-1:0] state_t;

    // single hprot bit kept per line
    typedef logic hprot_t;

    // named codes, stored as plain values by the arrays
    localparam state_t ST_INVALID   = 3'd0;
    localparam state_t ST_SHARED    = 3'd1;
    localparam state_t ST_EXCLUSIVE = 3'd2;
    localparam state_t ST_MODIFIED  = 3'd3;

endpackage

`default_nettype wire

// ==== l2_evict_store.sv ====
// per-set record of the way to evict next, registered read-first port
`default_nettype none

module l2_evict_store (
    input  wire logic                clk,
    input  wire logic                wr_rst,
    input  wire logic                rd_en,
    input  wire logic                wr_en_evict_way,
    input  wire l2_cfg_pkg::l2_set_t set_in,
    input  wire l2_cfg_pkg::l2_way_t wr_data_evict_way,
    output l2_cfg_pkg::l2_way_t      rd_data_evict_way
);

    l2_cfg_pkg::l2_way_t evict_mem [l2_cfg_pkg::L2_SETS];

    always_ff @(posedge clk) begin
        if (wr_en_evict_way) begin
            evict_mem[set_in] <= wr_data_evict_way;
        end
    end

    // output holds between reads
    always_ff @(posedge clk) begin
        if (wr_rst) begin
            rd_data_evict_way <= '0;
        end else if (rd_en) begin
            rd_data_evict_way <= evict_mem[set_in];
        end
    end

endmodule

`default_nettype wire

// ==== l2_localmem.sv ====
// top of the L2 storage: write decoder, one store per way and the evict store
// all read data is registered inside the stores, one cycle after rd_en
`default_nettype none

module l2_localmem (
    input  wire logic                clk,
    input  wire logic                wr_rst,
    input  wire logic                rd_en,
    input  wire logic                wr_en_line,
    input  wire logic                wr_en_state,
    input  wire logic                wr_en_evict_way,
    input  wire logic                wr_en_put_reqs,
    input  wire logic                wr_en_clear,
    input  wire l2_cfg_pkg::l2_set_t set_in,
    input  wire l2_cfg_pkg::l2_way_t way,
    input  wire l2_cfg_pkg::line_t   wr_data_line,
    input  wire l2_cfg_pkg::l2_tag_t wr_data_tag,
    input  wire l2_coh_pkg::hprot_t  wr_data_hprot,
    input  wire l2_cfg_pkg::l2_way_t wr_data_evict_way,
    input  wire l2_coh_pkg::state_t  wr_data_state,

    output l2_cfg_pkg::line_t        rd_data_line  [l2_cfg_pkg::L2_WAYS],
    output l2_cfg_pkg::l2_tag_t      rd_data_tag   [l2_cfg_pkg::L2_WAYS],
    output l2_coh_pkg::hprot_t       rd_data_hprot [l2_cfg_pkg::L2_WAYS],
    output l2_coh_pkg::state_t       rd_data_state [l2_cfg_pkg::L2_WAYS],
    output l2_cfg_pkg::l2_way_t      rd_data_evict_way
);

    // one write port per way
    l2_way_wr_if wr_bus [l2_cfg_pkg::L2_WAYS] ();

    l2_wr_decode wr_dec (
        .clk            (clk),
        .way            (way),
        .set_in         (set_in),
        .wr_data_line   (wr_data_line),
        .wr_data_tag    (wr_data_tag),
        .wr_data_hprot  (wr_data_hprot),
        .wr_data_state  (wr_data_state),
        .wr_en_line     (wr_en_line),
        .wr_en_state    (wr_en_state),
        .wr_en_put_reqs (wr_en_put_reqs),
        .wr_en_clear    (wr_en_clear),
        .wr_bus         (wr_bus)
    );

    for (genvar i = 0; i < l2_cfg_pkg::L2_WAYS; i++) begin : way_store
        l2_way_store store (
            .clk      (clk),
            .wr_rst   (wr_rst),
            .rd_en    (rd_en),
            .wr       (wr_bus[i]),
            .rd_line  (rd_data_line[i]),
            .rd_tag   (rd_data_tag[i]),
            .rd_hprot (rd_data_hprot[i]),
            .rd_state (rd_data_state[i])
        );
    end

    // evict way is per set, not per way, so it skips the decoder
    l2_evict_store evict_store (
        .clk               (clk),
        .wr_rst            (wr_rst),
        .rd_en             (rd_en),
        .wr_en_evict_way   (wr_en_evict_way),
        .set_in            (set_in),
        .wr_data_evict_way (wr_data_evict_way),
        .rd_data_evict_way (rd_data_evict_way)
    );

endmodule

`default_nettype wire

// ==== l2_localmem_assertions.sv ====
// concurrent checks on the per-way enables of the write decoder
// bound into every l2_wr_decode instance
`default_nettype none

module l2_localmem_assertions (
    input wire logic                           clk,
    input wire logic                           wr_en_clear,
    input wire logic [l2_cfg_pkg::L2_WAYS-1:0] we_line_vec,
    input wire logic [l2_cfg_pkg::L2_WAYS-1:0] we_tag_vec,
    input wire logic [l2_cfg_pkg::L2_WAYS-1:0] we_state_vec
);

    // only a clear may touch more than one way
    a_one_way: assert property (@(posedge clk)
        !wr_en_clear |-> $onehot0(we_line_vec | we_tag_vec | we_state_vec))
        else $error("more than one way has a write enable without clear");

    a_tag_with_line: assert property (@(posedge clk)
        (we_tag_vec & ~we_line_vec) == '0)
        else $error("tag write enabled without the line write");

    a_clear_all: assert property (@(posedge clk)
        wr_en_clear |-> (&we_state_vec))
        else $error("clear did not enable the state of every way");

endmodule

bind l2_wr_decode l2_localmem_assertions wr_dec_chk (
    .clk          (clk),
    .wr_en_clear  (wr_en_clear),
    .we_line_vec  (we_line_vec),
    .we_tag_vec   (we_tag_vec),
    .we_state_vec (we_state_vec)
);

`default_nettype wire

// ==== l2_way_store.sv ====
// line, tag, hprot and state arrays of one way
// each field has its own write enable, reads return the set one cycle after rd_en
`default_nettype none

module l2_way_store (
    input  wire logic                clk,
    input  wire logic                wr_rst,
    input  wire logic                rd_en,
    l2_way_wr_if.store               wr,
    output l2_cfg_pkg::line_t        rd_line,
    output l2_cfg_pkg::l2_tag_t      rd_tag,
    output l2_coh_pkg::hprot_t       rd_hprot,
    output l2_coh_pkg::state_t       rd_state
);

    l2_cfg_pkg::line_t   line_mem  [l2_cfg_pkg::L2_SETS];
    l2_cfg_pkg::l2_tag_t tag_mem   [l2_cfg_pkg::L2_SETS];
    l2_coh_pkg::hprot_t  hprot_mem [l2_cfg_pkg::L2_SETS];
    l2_coh_pkg::state_t  state_mem [l2_cfg_pkg::L2_SETS];

    always_ff @(posedge clk) begin
        if (wr.we_line) begin
            line_mem[wr.set] <= wr.line;
        end
    end

    // hprot travels with the tag
    always_ff @(posedge clk) begin
        if (wr.we_tag) begin
            tag_mem[wr.set]   <= wr.tag;
            hprot_mem[wr.set] <= wr.hprot;
        end
    end

    always_ff @(posedge clk) begin
        if (wr.we_state) begin
            state_mem[wr.set] <= wr.state;
        end
    end

    // read-first: a write on the same edge shows up only on the next read
    always_ff @(posedge clk) begin
        if (wr_rst) begin
            rd_line  <= '0;
            rd_tag   <= '0;
            rd_hprot <= '0;
            rd_state <= '0;
        end else if (rd_en) begin
            rd_line  <= line_mem[wr.set];
            rd_tag   <= tag_mem[wr.set];
            rd_hprot <= hprot_mem[wr.set];
            rd_state <= state_mem[wr.set];
        end
    end

endmodule

`default_nettype wire

// ==== l2_way_wr_if.sv ====
// write port of one way: address, field data and per-field enables
// driven by the write decoder, taken by one way store
`default_nettype none

interface l2_way_wr_if;

    l2_cfg_pkg::l2_set_t set;
    l2_cfg_pkg::line_t   line;
    l2_cfg_pkg::l2_tag_t tag;
    l2_coh_pkg::hprot_t  hprot;
    l2_coh_pkg::state_t  state;

    logic we_line;
    // also writes hprot
    logic we_tag;
    logic we_state;

    modport wr (
        output set, line, tag, hprot, state,
        output we_line, we_tag, we_state
    );

    modport store (
        input set, line, tag, hprot, state,
        input we_line, we_tag, we_state
    );

endinterface

`default_nettype wire

// ==== l2_wr_decode.sv ====
// turns the way select and the write strobes into per-way field enables
// and fans the write data out to every way
`default_nettype none

module l2_wr_decode (
    input  wire logic                clk,
    input  wire l2_cfg_pkg::l2_way_t way,
    input  wire l2_cfg_pkg::l2_set_t set_in,
    input  wire l2_cfg_pkg::line_t   wr_data_line,
    input  wire l2_cfg_pkg::l2_tag_t wr_data_tag,
    input  wire l2_coh_pkg::hprot_t  wr_data_hprot,
    input  wire l2_coh_pkg::state_t  wr_data_state,
    input  wire logic                wr_en_line,
    input  wire logic                wr_en_state,
    input  wire logic                wr_en_put_reqs,
    input  wire logic                wr_en_clear,
    l2_way_wr_if.wr                  wr_bus [l2_cfg_pkg::L2_WAYS]
);

    logic [l2_cfg_pkg::L2_WAYS-1:0] way_sel;
    logic [l2_cfg_pkg::L2_WAYS-1:0] we_line_vec;
    logic [l2_cfg_pkg::L2_WAYS-1:0] we_tag_vec;
    logic [l2_cfg_pkg::L2_WAYS-1:0] we_state_vec;

    // clear hits every way of the set
    always_comb begin
        for (int i = 0; i < l2_cfg_pkg::L2_WAYS; i++) begin
            way_sel[i] = wr_en_clear || (way == l2_cfg_pkg::l2_way_t'(i));
        end
    end

    assign we_line_vec  = way_sel & {l2_cfg_pkg::L2_WAYS{wr_en_line | wr_en_put_reqs}};
    assign we_tag_vec   = way_sel & {l2_cfg_pkg::L2_WAYS{wr_en_put_reqs}};
    assign we_state_vec = way_sel &
                          {l2_cfg_pkg::L2_WAYS{wr_en_state | wr_en_put_reqs | wr_en_clear}};

    for (genvar i = 0; i < l2_cfg_pkg::L2_WAYS; i++) begin : g_bus
        // data goes to all ways, only the enables differ
        assign wr_bus[i].set      = set_in;
        assign wr_bus[i].line     = wr_data_line;
        assign wr_bus[i].tag      = wr_data_tag;
        assign wr_bus[i].hprot    = wr_data_hprot;
        assign wr_bus[i].state    = wr_data_state;
        assign wr_bus[i].we_line  = we_line_vec[i];
        assign wr_bus[i].we_tag   = we_tag_vec[i];
        assign wr_bus[i].we_state = we_state_vec[i];
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the L2 storage testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
TOP=tb_l2_localmem

verilator --binary --timing --assert -j 0 \
    --top-module "$TOP" \
    --Mdir "$OBJ" -o "$TOP" \
    -f build.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Test completed successfully" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "pass message not found in $LOG"
    exit 1
fi

// ==== tb_l2_localmem.sv ====
// testbench for the L2 storage: drives writes and reads through the top level
// and checks every read output each cycle against a shadow model of the arrays
`default_nettype none

module tb_l2_localmem;

    // the six tests take about 600 cycles
    localparam int CYCLE_LIMIT = 5000;

    typedef struct packed {
        l2_cfg_pkg::line_t   line;
        l2_cfg_pkg::l2_tag_t tag;
        l2_coh_pkg::hprot_t  hprot;
        l2_coh_pkg::state_t  state;
    } way_rd_t;

    logic clk;
    logic wr_rst;
    logic rd_en;
    logic wr_en_line;
    logic wr_en_state;
    logic wr_en_evict_way;
    logic wr_en_put_reqs;
    logic wr_en_clear;
    l2_cfg_pkg::l2_set_t set_in;
    l2_cfg_pkg::l2_way_t way;
    l2_cfg_pkg::line_t   wr_data_line;
    l2_cfg_pkg::l2_tag_t wr_data_tag;
    l2_coh_pkg::hprot_t  wr_data_hprot;
    l2_cfg_pkg::l2_way_t wr_data_evict_way;
    l2_coh_pkg::state_t  wr_data_state;

    l2_cfg_pkg::line_t   rd_data_line  [l2_cfg_pkg::L2_WAYS];
    l2_cfg_pkg::l2_tag_t rd_data_tag   [l2_cfg_pkg::L2_WAYS];
    l2_coh_pkg::hprot_t  rd_data_hprot [l2_cfg_pkg::L2_WAYS];
    l2_coh_pkg::state_t  rd_data_state [l2_cfg_pkg::L2_WAYS];
    l2_cfg_pkg::l2_way_t rd_data_evict_way;

    // shadow arrays and the expected contents of the read registers
    l2_cfg_pkg::line_t   m_line  [l2_cfg_pkg::L2_WAYS][l2_cfg_pkg::L2_SETS];
    l2_cfg_pkg::l2_tag_t m_tag   [l2_cfg_pkg::L2_WAYS][l2_cfg_pkg::L2_SETS];
    l2_coh_pkg::hprot_t  m_hprot [l2_cfg_pkg::L2_WAYS][l2_cfg_pkg::L2_SETS];
    l2_coh_pkg::state_t  m_state [l2_cfg_pkg::L2_WAYS][l2_cfg_pkg::L2_SETS];
    l2_cfg_pkg::l2_way_t m_evict [l2_cfg_pkg::L2_SETS];
    way_rd_t             exp_rd  [l2_cfg_pkg::L2_WAYS];
    l2_cfg_pkg::l2_way_t exp_evict;

    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;
    int          test_count = 0;
    int          errors_at_start = 0;
    logic        check_on = 1'b0;
    logic [31:0] rng = 32'd4;

    l2_localmem dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic way_rd_t expected_read(input l2_cfg_pkg::l2_set_t s, input int w);
        way_rd_t r;
        r.line  = m_line[w][s];
        r.tag   = m_tag[w][s];
        r.hprot = m_hprot[w][s];
        r.state = m_state[w][s];
        return r;
    endfunction

    // model of the stores: read registers take the old contents, then writes apply
    always @(posedge clk) begin
        if (wr_rst) begin
            for (int w = 0; w < l2_cfg_pkg::L2_WAYS; w++) begin
                exp_rd[w] = '0;
            end
            exp_evict = '0;
        end else if (rd_en) begin
            for (int w = 0; w < l2_cfg_pkg::L2_WAYS; w++) begin
                exp_rd[w] = expected_read(set_in, w);
            end
            exp_evict = m_evict[set_in];
        end
        for (int w = 0; w < l2_cfg_pkg::L2_WAYS; w++) begin
            if (wr_en_clear || way == l2_cfg_pkg::l2_way_t'(w)) begin
                if (wr_en_line || wr_en_put_reqs) begin
                    m_line[w][set_in] = wr_data_line;
                end
                if (wr_en_put_reqs) begin
                    m_tag[w][set_in]   = wr_data_tag;
                    m_hprot[w][set_in] = wr_data_hprot;
                end
                if (wr_en_state || wr_en_put_reqs || wr_en_clear) begin
                    m_state[w][set_in] = wr_data_state;
                end
            end
        end
        if (wr_en_evict_way) begin
            m_evict[set_in] = wr_data_evict_way;
        end
    end

    task automatic check_line(input string name, input l2_cfg_pkg::line_t got,
                              input l2_cfg_pkg::line_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_tag(input string name, input l2_cfg_pkg::l2_tag_t got,
                             input l2_cfg_pkg::l2_tag_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_hprot(input string name, input l2_coh_pkg::hprot_t got,
                               input l2_coh_pkg::hprot_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_state(input string name, input l2_coh_pkg::state_t got,
                               input l2_coh_pkg::state_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_evict(input string name, input l2_cfg_pkg::l2_way_t got,
                               input l2_cfg_pkg::l2_way_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // mid-cycle compare, also catches outputs that move without a read
    always @(negedge clk) begin
        if (check_on) begin
            for (int w = 0; w < l2_cfg_pkg::L2_WAYS; w++) begin
                check_line($sformatf("rd_data_line[%0d]", w), rd_data_line[w], exp_rd[w].line);
                check_tag($sformatf("rd_data_tag[%0d]", w), rd_data_tag[w], exp_rd[w].tag);
                check_hprot($sformatf("rd_data_hprot[%0d]", w), rd_data_hprot[w],
                            exp_rd[w].hprot);
                check_state($sformatf("rd_data_state[%0d]", w), rd_data_state[w],
                            exp_rd[w].state);
            end
            check_evict("rd_data_evict_way", rd_data_evict_way, exp_evict);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    task automatic clear_strobes();
        rd_en           = 1'b0;
        wr_en_line      = 1'b0;
        wr_en_state     = 1'b0;
        wr_en_evict_way = 1'b0;
        wr_en_put_reqs  = 1'b0;
        wr_en_clear     = 1'b0;
    endtask

    // inputs set before this call are taken at the coming rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
        clear_strobes();
    endtask

    task automatic draw(output logic [31:0] r);
        rng = xorshift32(rng);
        r = rng;
    endtask

    task automatic put_way(input l2_cfg_pkg::l2_set_t s, input l2_cfg_pkg::l2_way_t w,
                           input l2_cfg_pkg::line_t line, input l2_cfg_pkg::l2_tag_t tag,
                           input l2_coh_pkg::hprot_t hp, input l2_coh_pkg::state_t st);
        set_in         = s;
        way            = w;
        wr_data_line   = line;
        wr_data_tag    = tag;
        wr_data_hprot  = hp;
        wr_data_state  = st;
        wr_en_put_reqs = 1'b1;
        next_cycle();
    endtask

    task automatic read_set(input l2_cfg_pkg::l2_set_t s);
        set_in = s;
        rd_en  = 1'b1;
        next_cycle();
    endtask

    task automatic random_cycle();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        draw(a);
        draw(b);
        draw(c);
        rd_en             = a[0];
        wr_en_line        = (a[3:1] == 3'd0);
        wr_en_state       = (a[6:4] == 3'd0);
        wr_en_put_reqs    = (a[9:7] == 3'd0);
        wr_en_clear       = (a[13:10] == 4'd0);
        wr_en_evict_way   = (a[16:14] == 3'd0);
        // half the sets only, so reads often hit freshly written data
        set_in            = {1'b0, a[19:17]};
        way               = a[22:21];
        wr_data_line      = {b, c};
        wr_data_tag       = c[11:0];
        wr_data_hprot     = c[12];
        wr_data_state     = c[15:13];
        wr_data_evict_way = c[17:16];
        next_cycle();
    endtask

    task automatic end_test(input string name);
        next_cycle();
        test_count++;
        $display("test %0d %s: %0d errors", test_count, name, error_count - errors_at_start);
        errors_at_start = error_count;
    endtask

    initial begin
        logic [31:0]        r1;
        logic [31:0]        r2;
        logic [31:0]        r3;
        l2_coh_pkg::state_t clear_codes [4];
        clear_codes[0] = l2_coh_pkg::ST_SHARED;
        clear_codes[1] = l2_coh_pkg::ST_EXCLUSIVE;
        clear_codes[2] = l2_coh_pkg::ST_MODIFIED;
        clear_codes[3] = l2_coh_pkg::ST_INVALID;
        clear_strobes();
        wr_rst            = 1'b1;
        set_in            = '0;
        way               = '0;
        wr_data_line      = '0;
        wr_data_tag       = '0;
        wr_data_hprot     = '0;
        wr_data_evict_way = '0;
        wr_data_state     = '0;
        repeat (8) @(posedge clk);
        #1;
        wr_rst   = 1'b0;
        check_on = 1'b1;

        // load nonzero read data first so the reset below has something to clear
        wr_en_evict_way   = 1'b1;
        wr_data_evict_way = 2'd3;
        put_way(4'd0, 2'd0, 64'h0123_4567_89ab_cdef, 12'habc, 1'b1,
                l2_coh_pkg::ST_MODIFIED);
        read_set(4'd0);
        wr_rst = 1'b1;
        next_cycle();
        wr_rst = 1'b0;
        repeat (3) next_cycle();
        end_test("reset");

        // every way of every set, tag carries way and set so ways differ
        for (int s = 0; s < l2_cfg_pkg::L2_SETS; s++) begin
            for (int w = 0; w < l2_cfg_pkg::L2_WAYS; w++) begin
                draw(r1);
                draw(r2);
                draw(r3);
                wr_en_evict_way   = (w == 0);
                wr_data_evict_way = r3[9:8];
                put_way(l2_cfg_pkg::l2_set_t'(s), l2_cfg_pkg::l2_way_t'(w), {r1, r2},
                        {r3[5:0], l2_cfg_pkg::l2_way_t'(w), l2_cfg_pkg::l2_set_t'(s)},
                        r3[6], l2_coh_pkg::state_t'(w));
            end
        end
        for (int s = 0; s < l2_cfg_pkg::L2_SETS; s++) begin
            read_set(l2_cfg_pkg::l2_set_t'(s));
        end
        end_test("put_reqs");

        for (int k = 0; k < 8; k++) begin
            draw(r1);
            draw(r2);
            set_in        = r1[3:0];
            way           = r1[5:4];
            wr_data_line  = {r2, r1};
            wr_data_tag   = r2[11:0];
            wr_data_hprot = r2[20];
            wr_en_line    = 1'b1;
            next_cycle();
            read_set(r1[3:0]);
            set_in        = r1[3:0];
            way           = r1[5:4];
            wr_data_line  = '1;
            wr_data_state = r2[14:12];
            wr_en_state   = 1'b1;
            next_cycle();
            read_set(r1[3:0]);
        end
        end_test("partial writes");

        for (int k = 0; k < 4; k++) begin
            draw(r1);
            set_in        = r1[3:0];
            way           = r1[5:4];
            wr_data_line  = {r1, r1};
            wr_data_tag   = r1[27:16];
            wr_data_state = clear_codes[k];
            wr_en_clear   = 1'b1;
            next_cycle();
            read_set(r1[3:0]);
            read_set(r1[3:0] + 4'd1);
        end
        end_test("clear");

        for (int s = 0; s < l2_cfg_pkg::L2_SETS; s++) begin
            draw(r1);
            set_in            = l2_cfg_pkg::l2_set_t'(s);
            wr_data_evict_way = r1[1:0];
            wr_en_evict_way   = 1'b1;
            next_cycle();
        end
        for (int s = 0; s < l2_cfg_pkg::L2_SETS; s++) begin
            read_set(l2_cfg_pkg::l2_set_t'(s));
        end
        read_set(4'd9);
        // no strobes: outputs must keep the set 9 values
        repeat (8) begin
            draw(r1);
            draw(r2);
            set_in            = r1[3:0];
            way               = r1[5:4];
            wr_data_line      = {r1, r2};
            wr_data_tag       = r2[11:0];
            wr_data_evict_way = r2[13:12];
            wr_data_state     = r2[16:14];
            next_cycle();
        end
        end_test("evict way and hold");

        repeat (400) random_cycle();
        end_test("random mix");

        $display("summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
                 error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
